/* flist.f */
source/ppu_pkg.sv
source/scan_counter.sv
source/line_phase_fsm.sv
source/sprite_attribute_table.sv
source/sprite_evaluator.sv
source/sprite_slot_driver.sv
source/ppu_sprite_engine.sv
testbench/tb_clock_gen.sv
testbench/ppu_sprite_engine_asserts.sv
testbench/tb_ppu_sprite_engine.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ppu_sprite_engine
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+10

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/tb_ppu_sprite_engine.sv */
`default_nettype none

module tb_ppu_sprite_engine import ppu_pkg::*; ();

    localparam int clock_period   = 40;
    localparam int drive_delay    = 5;
    localparam int frame_count    = 3;
    localparam int line_count     = 5;
    localparam int vblank_cycles  = 270;
    localparam int hsync_cycles   = 150;
    localparam int active_columns = 640;
    localparam int load_latency   = 139;
    localparam int load_timeout   = 200;
    localparam int pattern_rows   = 2048;
    // A crowd of sprites on one line to overflow the eight slots
    localparam int cluster_size   = 12;
    localparam int cluster_y      = 100;
    localparam int line_cycles    = hsync_cycles + active_columns + 2;
    localparam int frame_cycles   = vblank_cycles + 1 + line_count * line_cycles;
    localparam int watchdog_time  = (frame_count * frame_cycles + 200) * clock_period;

    logic                          clk;
    logic                          reset;
    logic                          vblank;
    logic                          hsync;
    vcount_t                       vcount;
    hcount_t                       hcount;
    oam_addr_t                     oam_addr;
    oam_word_t                     oam_data = '0;
    pattern_addr_t                 pattern_addr;
    pattern_row_t                  pattern_data = '0;
    pattern_row_t [slot_count-1:0] shift_load_data;
    logic                          shift_load_sprite;
    logic [slot_count-1:0]         shift_enable;
    logic                          seen_load;

    oam_word_t     oam_mem [oam_words];
    pattern_row_t  pat_mem [pattern_rows];
    int            exp_used;
    int            exp_x [slot_count];
    pattern_addr_t exp_addr [slot_count];
    pattern_row_t  exp_row [slot_count];
    logic          exp_hflip [slot_count];

    tb_clock_gen i_clock_gen (
        .clk (clk)
    );

    ppu_sprite_engine i_ppu_sprite_engine (
        .clk               (clk),
        .reset             (reset),
        .vblank            (vblank),
        .hsync             (hsync),
        .vcount            (vcount),
        .hcount            (hcount),
        .oam_addr          (oam_addr),
        .oam_data          (oam_data),
        .pattern_addr      (pattern_addr),
        .pattern_data      (pattern_data),
        .shift_load_data   (shift_load_data),
        .shift_load_sprite (shift_load_sprite),
        .shift_enable      (shift_enable)
    );

    // Both memories answer one cycle after the address
    always @(posedge clk) begin
        oam_data     <= #drive_delay oam_mem[oam_addr];
        pattern_data <= #drive_delay pat_mem[pattern_addr];
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got == want) else begin
            report_failure($sformatf("mismatch at %0t: %s expected %0h, got %0h",
                                     $time, name, want, got));
        end
    endtask

    function automatic logic [31:0] reverse_bits(input logic [31:0] word);
        logic [31:0] result;
        for (int i = 0; i < 32; i++) begin
            result[i] = word[31 - i];
        end
        return result;
    endfunction

    task automatic fill_pattern_memory();
        // Low bits carry the row address so a delivered row names itself
        for (int a = 0; a < pattern_rows; a++) begin
            pat_mem[a] = {21'($urandom()), 11'(a)};
        end
    endtask

    task automatic fill_oam();
        int y;
        for (int k = 0; k < sprite_count; k++) begin
            y = (k < cluster_size) ? cluster_y : int'($urandom_range(0, 255));
            oam_mem[2 * k]     = $urandom();
            oam_mem[2 * k + 1] = {16'(y), 16'($urandom_range(0, 650))};
        end
    endtask

    // First eight sprites by index that cover line v
    task automatic predict_line(input int v);
        int        y;
        int        offset;
        oam_word_t word;
        exp_used = 0;
        for (int s = 0; s < slot_count; s++) begin
            exp_row[s]   = '0;
            exp_hflip[s] = 1'b0;
        end
        for (int k = 0; k < sprite_count; k++) begin
            y = int'(oam_mem[2 * k + 1][31:16]);
            if (y <= v && v < y + sprite_size && exp_used < slot_count) begin
                word   = oam_mem[2 * k];
                offset = word[31] ? sprite_size - 1 - (v - y) : v - y;
                exp_addr[exp_used]  = pattern_addr_t'(int'(word[6:0]) * sprite_size + offset);
                exp_hflip[exp_used] = word[30];
                exp_row[exp_used]   = word[30] ? reverse_bits(pat_mem[exp_addr[exp_used]])
                                               : pat_mem[exp_addr[exp_used]];
                exp_x[exp_used]     = int'(oam_mem[2 * k + 1][15:0]);
                exp_used++;
            end
        end
    endtask

    task automatic run_vblank();
        vblank = 1'b1;
        repeat (vblank_cycles) begin
            @(posedge clk);
            #drive_delay;
        end
        vblank = 1'b0;
        // Lets the FSM return to idle before the first hsync
        @(posedge clk);
        #drive_delay;
    endtask

    task automatic run_line(input int v);
        int                    cycles;
        logic [31:0]           back;
        logic [slot_count-1:0] want_enable;
        predict_line(v);
        vcount = vcount_t'(v);
        hcount = '0;
        hsync  = 1'b1;
        cycles = 0;
        while (!shift_load_sprite && cycles <= load_timeout) begin
            @(posedge clk);
            #drive_delay;
            cycles++;
        end
        if (!shift_load_sprite) begin
            report_failure($sformatf("no load pulse after hsync on line %0d", v));
        end
        seen_load = 1'b1;
        check_value("load latency", 32'(cycles), 32'(load_latency));
        for (int s = 0; s < slot_count; s++) begin
            if (s < exp_used) begin
                back = exp_hflip[s] ? reverse_bits(shift_load_data[s]) : shift_load_data[s];
                check_value($sformatf("row address of slot %0d", s),
                            32'(back[10:0]), 32'(exp_addr[s]));
            end
            check_value($sformatf("shift_load_data[%0d]", s), shift_load_data[s], exp_row[s]);
        end
        repeat (hsync_cycles - cycles) begin
            @(posedge clk);
            #drive_delay;
        end
        hsync = 1'b0;
        @(posedge clk);
        #drive_delay;
        // Enables are registered, so each check looks at the previous column
        for (int h = 0; h < active_columns; h++) begin
            @(posedge clk);
            #drive_delay;
            for (int s = 0; s < slot_count; s++) begin
                want_enable[s] = (s < exp_used) && (h >= exp_x[s])
                    && (h < exp_x[s] + sprite_size);
            end
            check_value("shift_enable", 32'(shift_enable), 32'(want_enable));
            if (h < active_columns - 1) begin
                hcount = hcount_t'(h + 1);
            end
        end
        for (int s = 0; s < slot_count; s++) begin
            check_value($sformatf("shift_load_data[%0d] after display", s),
                        shift_load_data[s], exp_row[s]);
        end
    endtask

    always @(negedge clk) begin
        if (i_ppu_sprite_engine.i_asserts.failures != 0) begin
            report_failure("a protocol assertion on the DUT outputs failed");
        end
        if (!reset && !seen_load) begin
            check_value("shift_load_sprite", 32'(shift_load_sprite), 32'h0);
            check_value("shift_enable", 32'(shift_enable), 32'h0);
            for (int s = 0; s < slot_count; s++) begin
                check_value($sformatf("shift_load_data[%0d]", s), shift_load_data[s], 32'h0);
            end
        end
    end

    initial begin
        #watchdog_time;
        report_failure("watchdog expired before the frames finished");
    end

    initial begin
        void'($urandom(32'h368d));
        seen_load = 1'b0;
        reset     = 1'b1;
        vblank    = 1'b0;
        hsync     = 1'b0;
        vcount    = '0;
        hcount    = '0;
        fill_pattern_memory();
        repeat (2) @(posedge clk);
        #drive_delay;
        reset = 1'b0;
        for (int f = 0; f < frame_count; f++) begin
            fill_oam();
            run_vblank();
            for (int l = 0; l < line_count; l++) begin
                if (l == 0) begin
                    run_line(cluster_y + f);
                end else begin
                    run_line(int'($urandom_range(0, 271)));
                end
            end
        end
        if (i_ppu_sprite_engine.i_asserts.failures != 0) begin
            report_failure("a protocol assertion on the DUT outputs failed");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* testbench/ppu_sprite_engine_asserts.sv */
`default_nettype none

module ppu_sprite_engine_asserts import ppu_pkg::*; (
    input logic                  clk,
    input logic                  reset,
    input logic                  vblank,
    input logic                  hsync,
    input logic                  shift_load_sprite,
    input logic [slot_count-1:0] shift_enable
);

    // Read by the testbench top
    int unsigned failures = 0;

    load_single_cycle: assert property (@(posedge clk) disable iff (reset)
        shift_load_sprite |=> !shift_load_sprite)
        else begin
            failures++;
            $error("shift_load_sprite stayed high for two cycles");
        end

    // The row load belongs to the line sequence started by hsync
    load_inside_hsync: assert property (@(posedge clk) disable iff (reset)
        shift_load_sprite |-> hsync)
        else begin
            failures++;
            $error("shift_load_sprite high while hsync is low");
        end

    // Registered enables stay clear through a strobe and the cycle it falls
    enable_quiet_in_blank: assert property (@(posedge clk) disable iff (reset)
        (vblank || hsync) |=> (shift_enable == '0))
        else begin
            failures++;
            $error("shift_enable active during or right after vblank or hsync");
        end

endmodule

bind ppu_sprite_engine ppu_sprite_engine_asserts i_asserts (
    .clk               (clk),
    .reset             (reset),
    .vblank            (vblank),
    .hsync             (hsync),
    .shift_load_sprite (shift_load_sprite),
    .shift_enable      (shift_enable)
);

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    localparam int half_period = 20;

    initial begin
        clk = 1'b0;
    end

    always #half_period clk = ~clk;

endmodule

`default_nettype wire

/* source/ppu_sprite_engine.sv */
`default_nettype none

module ppu_sprite_engine import ppu_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          vblank,
    input  logic                          hsync,
    input  vcount_t                       vcount,
    input  hcount_t                       hcount,
    output oam_addr_t                     oam_addr,
    input  oam_word_t                     oam_data,
    output pattern_addr_t                 pattern_addr,
    input  pattern_row_t                  pattern_data,
    output pattern_row_t [slot_count-1:0] shift_load_data,
    output logic                          shift_load_sprite,
    output logic [slot_count-1:0]         shift_enable
);

    phase_t        phase;
    step_t         step;
    logic          last;
    sprite_attr_t  scan_attr;
    sprite_attr_t  fetch_attr;
    sprite_index_t fetch_index;
    slot_list_t    slots;

    scan_counter i_scan_counter (
        .clk   (clk),
        .reset (reset),
        .phase (phase),
        .step  (step),
        .last  (last)
    );

    line_phase_fsm i_line_phase_fsm (
        .clk    (clk),
        .reset  (reset),
        .vblank (vblank),
        .hsync  (hsync),
        .last   (last),
        .phase  (phase)
    );

    sprite_attribute_table i_sprite_attribute_table (
        .clk         (clk),
        .reset       (reset),
        .phase       (phase),
        .step        (step),
        .oam_addr    (oam_addr),
        .oam_data    (oam_data),
        .scan_attr   (scan_attr),
        .fetch_index (fetch_index),
        .fetch_attr  (fetch_attr)
    );

    sprite_evaluator i_sprite_evaluator (
        .clk       (clk),
        .reset     (reset),
        .phase     (phase),
        .step      (step),
        .vcount    (vcount),
        .scan_attr (scan_attr),
        .slots     (slots)
    );

    sprite_slot_driver i_sprite_slot_driver (
        .clk               (clk),
        .reset             (reset),
        .vblank            (vblank),
        .hsync             (hsync),
        .phase             (phase),
        .step              (step),
        .vcount            (vcount),
        .hcount            (hcount),
        .slots             (slots),
        .fetch_index       (fetch_index),
        .fetch_attr        (fetch_attr),
        .pattern_addr      (pattern_addr),
        .pattern_data      (pattern_data),
        .shift_load_data   (shift_load_data),
        .shift_load_sprite (shift_load_sprite),
        .shift_enable      (shift_enable)
    );

endmodule

`default_nettype wire

/* source/sprite_slot_driver.sv */
`default_nettype none

module sprite_slot_driver import ppu_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          vblank,
    input  logic                          hsync,
    input  phase_t                        phase,
    input  step_t                         step,
    input  vcount_t                       vcount,
    input  hcount_t                       hcount,
    input  slot_list_t                    slots,
    output sprite_index_t                 fetch_index,
    input  sprite_attr_t                  fetch_attr,
    output pattern_addr_t                 pattern_addr,
    input  pattern_row_t                  pattern_data,
    output pattern_row_t [slot_count-1:0] shift_load_data,
    output logic                          shift_load_sprite,
    output logic [slot_count-1:0]         shift_enable
);

    slot_index_t                   fetch_slot;
    logic                          fetch_active;
    logic [3:0]                    line_row;
    logic [3:0]                    tile_row;
    pattern_row_t                  row_reversed;
    // Fetch in flight, stored when the memory answers
    logic                          pend_valid;
    slot_index_t                   pend_slot;
    logic                          pend_hflip;
    pattern_row_t [slot_count-1:0] rows;
    coord_t [slot_count-1:0]       slot_x;
    logic [slot_count-1:0]         slot_live;
    coord_t                        hpos;
    logic [slot_count-1:0]         in_span;
    logic [slot_count-1:0]         enable_q;

    assign fetch_slot   = slot_index_t'(step);
    assign fetch_active = (phase == fetch) && (step < step_t'(slot_count));
    assign fetch_index  = slots.index[fetch_slot];

    // Row within the tile, mirrored top to bottom under vertical flip
    assign line_row     = vcount[3:0] - fetch_attr.y[3:0];
    assign tile_row     = fetch_attr.vflip ? 4'(sprite_size - 1) - line_row : line_row;
    assign pattern_addr = fetch_active ? {fetch_attr.tile, tile_row} : '0;
    assign row_reversed = {<<{pattern_data}};

    always_ff @(posedge clk) begin
        if (reset) begin
            pend_valid <= 1'b0;
            pend_slot  <= '0;
            pend_hflip <= 1'b0;
            slot_live  <= '0;
        end else begin
            pend_valid <= fetch_active;
            if (fetch_active) begin
                pend_slot             <= fetch_slot;
                pend_hflip            <= fetch_attr.hflip;
                slot_live[fetch_slot] <= slot_count_t'(fetch_slot) < slots.used;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_active) begin
            slot_x[fetch_slot] <= fetch_attr.x;
        end
        if (pend_valid) begin
            // Empty slots get a blank row
            if (!slot_live[pend_slot]) begin
                rows[pend_slot] <= '0;
            end else if (pend_hflip) begin
                rows[pend_slot] <= row_reversed;
            end else begin
                rows[pend_slot] <= pattern_data;
            end
        end
    end

    assign hpos = coord_t'(hcount);

    always_comb begin
        for (int i = 0; i < slot_count; i++) begin
            in_span[i] = slot_live[i] && (hpos >= slot_x[i])
                && ({1'b0, hpos} < {1'b0, slot_x[i]} + 17'(sprite_size));
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            shift_load_sprite <= 1'b0;
            shift_load_data   <= '0;
            enable_q          <= '0;
        end else begin
            shift_load_sprite <= (phase == load);
            if (phase == load) begin
                shift_load_data <= rows;
            end
            enable_q <= (phase == idle) ? in_span : '0;
        end
    end

    // Strobes mask the registered enables in the cycle they rise
    assign shift_enable = enable_q & {slot_count{~(vblank | hsync)}};

endmodule

`default_nettype wire

/* source/sprite_evaluator.sv */
`default_nettype none

module sprite_evaluator import ppu_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  phase_t       phase,
    input  step_t        step,
    input  vcount_t      vcount,
    input  sprite_attr_t scan_attr,
    output slot_list_t   slots
);

    coord_t      line;
    logic [16:0] y_end;
    logic        covers;
    slot_list_t  base;
    slot_list_t  slots_next;

    // Extra bit keeps y plus height from wrapping near the top of the range
    assign line   = coord_t'(vcount);
    assign y_end  = {1'b0, scan_attr.y} + 17'(sprite_size);
    assign covers = (line >= scan_attr.y) && ({1'b0, line} < y_end);

    always_comb begin
        // Step zero starts a fresh list for this line
        base       = (step == '0) ? '0 : slots;
        slots_next = base;
        if (covers && (base.used < slot_count_t'(slot_count))) begin
            slots_next.index[slot_index_t'(base.used)] = sprite_index_t'(step);
            slots_next.used = base.used + 1'b1;
        end
    end

    // Sprites past the eighth hit are dropped by the used check
    always_ff @(posedge clk) begin
        if (reset) begin
            slots <= '0;
        end else if (phase == evaluate) begin
            slots <= slots_next;
        end
    end

endmodule

`default_nettype wire

/* source/sprite_attribute_table.sv */
`default_nettype none

module sprite_attribute_table import ppu_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  phase_t        phase,
    input  step_t         step,
    output oam_addr_t     oam_addr,
    input  oam_word_t     oam_data,
    output sprite_attr_t  scan_attr,
    input  sprite_index_t fetch_index,
    output sprite_attr_t  fetch_attr
);

    sprite_attr_t  table_q [sprite_count];
    logic          addr_active;
    // Address presented last cycle, whose word is on oam_data now
    oam_addr_t     wr_addr;
    logic          wr_valid;
    sprite_index_t wr_entry;

    assign addr_active = (phase == oam_load) && (step < step_t'(oam_words));
    assign oam_addr    = addr_active ? oam_addr_t'(step) : '0;
    assign wr_entry    = wr_addr[7:1];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_addr  <= '0;
            wr_valid <= 1'b0;
            for (int i = 0; i < sprite_count; i++) begin
                table_q[i] <= '0;
            end
        end else begin
            wr_addr  <= oam_addr;
            wr_valid <= addr_active;
            if (wr_valid) begin
                if (wr_addr[0]) begin
                    // Odd word holds the position
                    table_q[wr_entry].x <= oam_data[15:0];
                    table_q[wr_entry].y <= oam_data[31:16];
                end else begin
                    // Even word holds tile number and rotation
                    table_q[wr_entry].tile  <= oam_data[6:0];
                    table_q[wr_entry].vflip <= oam_data[31];
                    table_q[wr_entry].hflip <= oam_data[30];
                end
            end
        end
    end

    // Evaluation walks the table by step, fetch looks up by slot
    assign scan_attr  = table_q[sprite_index_t'(step)];
    assign fetch_attr = table_q[fetch_index];

endmodule

`default_nettype wire

/* source/line_phase_fsm.sv */
`default_nettype none

module line_phase_fsm import ppu_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   vblank,
    input  logic   hsync,
    input  logic   last,
    output phase_t phase
);

    phase_t phase_next;

    always_comb begin
        phase_next = phase;
        case (phase)
            idle: begin
                // Vblank wins if both strobes are seen together
                if (vblank) begin
                    phase_next = oam_load;
                end else if (hsync) begin
                    phase_next = evaluate;
                end
            end
            oam_load: begin
                if (last) begin
                    phase_next = oam_done;
                end
            end
            oam_done: begin
                if (!vblank) begin
                    phase_next = idle;
                end
            end
            evaluate: begin
                if (last) begin
                    phase_next = fetch;
                end
            end
            fetch: begin
                if (last) begin
                    phase_next = load;
                end
            end
            load: begin
                if (last) begin
                    phase_next = line_done;
                end
            end
            line_done: begin
                // Hold here so one hsync gives exactly one line sequence
                if (!hsync) begin
                    phase_next = idle;
                end
            end
            default: phase_next = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= idle;
        end else begin
            phase <= phase_next;
        end
    end

endmodule

`default_nettype wire

/* source/scan_counter.sv */
`default_nettype none

module scan_counter import ppu_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  phase_t phase,
    output step_t  step,
    output logic   last
);

    phase_t prev_phase;
    step_t  count;
    logic   restart;

    // First cycle of a new phase always reads as step zero
    assign restart = (phase != prev_phase);
    assign step    = restart ? '0 : count;

    always_ff @(posedge clk) begin
        if (reset) begin
            prev_phase <= idle;
            count      <= '0;
        end else begin
            prev_phase <= phase;
            count      <= step + 1'b1;
        end
    end

    always_comb begin
        case (phase)
            // One extra step to store the word read on the final address
            oam_load: last = (step == step_t'(oam_words));
            evaluate: last = (step == step_t'(sprite_count - 1));
            // Eight addresses plus one trailing store
            fetch:    last = (step == step_t'(slot_count));
            load:     last = (step == '0);
            default:  last = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* source/ppu_pkg.sv */
`default_nettype none

package ppu_pkg;

    // Sizes fixed by the OAM and line format
    localparam int sprite_count = 128;
    localparam int slot_count   = 8;
    localparam int sprite_size  = 16;
    // Two words per sprite entry
    localparam int oam_words    = 2 * sprite_count;

    typedef logic [6:0]  sprite_index_t;
    typedef logic [2:0]  slot_index_t;
    typedef logic [3:0]  slot_count_t;
    typedef logic [15:0] coord_t;
    typedef logic [9:0]  vcount_t;
    typedef logic [10:0] hcount_t;
    typedef logic [8:0]  step_t;
    typedef logic [7:0]  oam_addr_t;
    typedef logic [31:0] oam_word_t;
    typedef logic [10:0] pattern_addr_t;
    // 16 pixels at two bits each
    typedef logic [31:0] pattern_row_t;

    typedef enum logic [2:0] {
        idle,
        oam_load,
        oam_done,
        evaluate,
        fetch,
        load,
        line_done
    } phase_t;

    typedef struct packed {
        coord_t     x;
        coord_t     y;
        logic [6:0] tile;
        logic       vflip;
        logic       hflip;
    } sprite_attr_t;

    typedef struct packed {
        slot_count_t                    used;
        sprite_index_t [slot_count-1:0] index;
    } slot_list_t;

endpackage

`default_nettype wire
